// ==== Makefile ====
TOP := kbd_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	rm -f $(LOG)
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/byte_link_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Credit-based byte link from the PS/2 receiver into the scan-code FIFO
interface byte_link_if;

    logic                valid;
    kbd_pkg::scan_byte_t data;
    logic                credit;

    // Sender side, spends one credit per valid pulse
    modport tx (
        output valid,
        output data,
        input  credit
    );

    // Receiver side, returns one credit per freed entry
    modport rx (
        input  valid,
        input  data,
        output credit
    );

endinterface

`default_nettype wire

// ==== design/kbd_config.svh ====
`ifndef KBD_CONFIG_SVH
`define KBD_CONFIG_SVH

// Scan-code FIFO entries, also the receiver's credit count after reset
`define KBD_FIFO_DEPTH 4

// Flip-flops in each PS/2 line synchronizer
`define KBD_SYNC_STAGES 2

// Prefix byte that announces a key release
`define KBD_BREAK_CODE 8'hF0

`endif

// ==== design/kbd_display_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module kbd_display_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    input  logic       freeze,
    output logic [7:0] seg_lo,
    output logic [7:0] seg_hi,
    output logic [7:0] press_count,
    output logic       overflow
);

    logic                avail;
    kbd_pkg::scan_byte_t head;
    logic                pop;
    logic [7:0]          shown_code;
    logic                shown;

    byte_link_if link ();

    ps2_rx u_rx (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .link     (link.tx),
        .overflow (overflow)
    );

    scan_fifo u_fifo (
        .clk   (clk),
        .rst   (rst),
        .link  (link.rx),
        .avail (avail),
        .head  (head),
        .pop   (pop)
    );

    key_tracker u_tracker (
        .clk         (clk),
        .rst         (rst),
        .freeze      (freeze),
        .avail       (avail),
        .head        (head),
        .pop         (pop),
        .shown_code  (shown_code),
        .shown       (shown),
        .press_count (press_count)
    );

    seg_display u_display (
        .clk    (clk),
        .rst    (rst),
        .code   (shown_code),
        .shown  (shown),
        .seg_lo (seg_lo),
        .seg_hi (seg_hi)
    );

endmodule

`default_nettype wire

// ==== design/kbd_pkg.sv ====
`default_nettype none

`include "kbd_config.svh"

package kbd_pkg;

    // One received scan byte as it travels from the receiver to the tracker
    typedef struct packed {
        logic [7:0] code;
        logic       err;
    } scan_byte_t;

    // Holds 0 up to the full FIFO depth
    typedef logic [$clog2(`KBD_FIFO_DEPTH + 1)-1:0] credit_t;

endpackage

`default_nettype wire

// ==== design/key_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kbd_config.svh"

module key_tracker (
    input  logic                clk,
    input  logic                rst,
    input  logic                freeze,
    input  logic                avail,
    input  kbd_pkg::scan_byte_t head,
    output logic                pop,
    output logic [7:0]          shown_code,
    output logic                shown,
    output logic [7:0]          press_count
);

    typedef enum logic [1:0] {
        IDLE,
        BREAK_PENDING,
        POP_WAIT
    } state_t;

    state_t              state;
    logic                in_break;
    kbd_pkg::scan_byte_t byte_q;
    logic                is_make;

    // One byte in flight at a time, it is decoded in POP_WAIT
    assign pop = avail && !freeze && (state != POP_WAIT);

    assign is_make = (state == POP_WAIT) && !byte_q.err && !in_break &&
                     (byte_q.code != `KBD_BREAK_CODE);

    always_ff @(posedge clk)
    begin
        if (pop)
            byte_q <= head;
        if (is_make)
            shown_code <= byte_q.code;
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state       <= IDLE;
            in_break    <= 1'b0;
            shown       <= 1'b0;
            press_count <= 8'd0;
        end
        else
        begin
            case (state)
                IDLE, BREAK_PENDING:
                begin
                    if (pop)
                    begin
                        in_break <= (state == BREAK_PENDING);
                        state    <= POP_WAIT;
                    end
                end
                POP_WAIT:
                begin
                    if (byte_q.err)
                        state <= IDLE;
                    else if (in_break)
                    begin
                        // Releasing some other key leaves the display alone
                        if (byte_q.code == shown_code)
                            shown <= 1'b0;
                        state <= IDLE;
                    end
                    else if (byte_q.code == `KBD_BREAK_CODE)
                        state <= BREAK_PENDING;
                    else
                    begin
                        shown       <= 1'b1;
                        press_count <= press_count + 8'd1;
                        state       <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/ps2_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kbd_config.svh"

module ps2_rx (
    input  logic    clk,
    input  logic    rst,
    input  logic    ps2_clk,
    input  logic    ps2_dat,
    byte_link_if.tx link,
    output logic    overflow
);

    localparam int SYNC = `KBD_SYNC_STAGES;

    logic [SYNC-1:0]  clk_sync;
    logic [SYNC-1:0]  dat_sync;
    logic             clk_prev;
    logic             data_bit;
    logic             fall;
    logic [3:0]       bit_cnt;
    logic [7:0]       shift_q;
    logic             parity_q;
    logic             frame_done;
    logic             frame_err;
    logic             spend;
    kbd_pkg::credit_t credits;

    // Both lines idle high, so the synchronizers come out of reset at one
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= '1;
            dat_sync <= '1;
            clk_prev <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[SYNC-2:0], ps2_clk};
            dat_sync <= {dat_sync[SYNC-2:0], ps2_dat};
            clk_prev <= clk_sync[SYNC-1];
        end
    end

    assign data_bit = dat_sync[SYNC-1];
    assign fall     = clk_prev & ~clk_sync[SYNC-1];

    // Bit 0 is the start bit, 1 to 8 data, 9 parity and 10 the stop bit
    always_ff @(posedge clk)
    begin
        if (!rst)
            bit_cnt <= 4'd0;
        else if (fall)
        begin
            if (bit_cnt == 4'd0)
            begin
                if (!data_bit)
                    bit_cnt <= 4'd1;
            end
            else if (bit_cnt == 4'd10)
                bit_cnt <= 4'd0;
            else
                bit_cnt <= bit_cnt + 4'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fall && bit_cnt >= 4'd1 && bit_cnt <= 4'd8)
            shift_q <= {data_bit, shift_q[7:1]};
        if (fall && bit_cnt == 4'd9)
            parity_q <= data_bit;
    end

    assign frame_done = fall && (bit_cnt == 4'd10);
    // Odd parity over data and parity bit, and the stop bit must be high
    assign frame_err  = ~(^{shift_q, parity_q}) | ~data_bit;
    assign spend      = frame_done && (credits != '0);

    always_ff @(posedge clk)
    begin
        if (frame_done)
            link.data <= '{code: shift_q, err: frame_err};
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            link.valid <= 1'b0;
            overflow   <= 1'b0;
            credits    <= kbd_pkg::credit_t'(`KBD_FIFO_DEPTH);
        end
        else
        begin
            link.valid <= spend;
            // The keyboard cannot be held off, so a byte without credit is lost
            if (frame_done && credits == '0)
                overflow <= 1'b1;
            case ({spend, link.credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/scan_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kbd_config.svh"

module scan_fifo (
    input  logic                clk,
    input  logic                rst,
    byte_link_if.rx             link,
    output logic                avail,
    output kbd_pkg::scan_byte_t head,
    input  logic                pop
);

    localparam int DEPTH = `KBD_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    kbd_pkg::scan_byte_t mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    kbd_pkg::credit_t    count;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1))
            return '0;
        else
            return p + 1'b1;
    endfunction

    // The sender holds a credit for every push, so there is always room
    always_ff @(posedge clk)
    begin
        if (link.valid)
            mem[wr_ptr] <= link.data;
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            link.credit <= 1'b0;
        end
        else
        begin
            if (link.valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({link.valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            link.credit <= pop;
        end
    end

    assign avail = (count != '0);
    assign head  = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== design/seg_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module seg_display (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] code,
    input  logic       shown,
    output logic [7:0] seg_lo,
    output logic [7:0] seg_hi
);

    // Active-low segments in gfedcba order
    function automatic logic [6:0] hex_seg(input logic [3:0] n);
        case (n)
            4'h0:    return 7'b1000000;
            4'h1:    return 7'b1111001;
            4'h2:    return 7'b0100100;
            4'h3:    return 7'b0110000;
            4'h4:    return 7'b0011001;
            4'h5:    return 7'b0010010;
            4'h6:    return 7'b0000010;
            4'h7:    return 7'b1111000;
            4'h8:    return 7'b0000000;
            4'h9:    return 7'b0010000;
            4'ha:    return 7'b0001000;
            4'hb:    return 7'b0000011;
            4'hc:    return 7'b1000110;
            4'hd:    return 7'b0100001;
            4'he:    return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    // Decimal point stays dark, bit 7 is always one
    always_ff @(posedge clk)
    begin
        if (!rst || !shown)
        begin
            seg_lo <= 8'hff;
            seg_hi <= 8'hff;
        end
        else
        begin
            seg_lo <= {1'b1, hex_seg(code[3:0])};
            seg_hi <= {1'b1, hex_seg(code[7:4])};
        end
    end

endmodule

`default_nettype wire

// ==== dv/kbd_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kbd_config.svh"

module kbd_props (
    input  logic             clk,
    input  logic             rst,
    input  logic             valid,
    input  kbd_pkg::credit_t level,
    input  logic             pop,
    input  logic             avail,
    input  logic             overflow
);

    localparam int DEPTH = `KBD_FIFO_DEPTH;

    // A push from the receiver only arrives while the FIFO still has a free entry
    push_has_room: assert property (@(posedge clk) disable iff (!rst)
        valid |-> (level != kbd_pkg::credit_t'(DEPTH)))
        else $error("push arrived at a full FIFO");

    level_in_range: assert property (@(posedge clk) disable iff (!rst)
        level <= kbd_pkg::credit_t'(DEPTH))
        else $error("credit or entry count above the FIFO depth");

    pop_needs_avail: assert property (@(posedge clk) disable iff (!rst)
        pop |-> avail)
        else $error("pop while the FIFO is empty");

    // Only a reset clears the sticky overflow
    overflow_sticky: assert property (@(posedge clk)
        $fell(overflow) |-> !$past(rst))
        else $error("overflow fell without reset");

endmodule

bind ps2_rx kbd_props u_rx_props (
    .clk      (clk),
    .rst      (rst),
    .valid    (1'b0),
    .level    (credits),
    .pop      (1'b0),
    .avail    (1'b1),
    .overflow (overflow)
);

bind scan_fifo kbd_props u_fifo_props (
    .clk      (clk),
    .rst      (rst),
    .valid    (link.valid),
    .level    (count),
    .pop      (pop),
    .avail    (avail),
    .overflow (1'b0)
);

`default_nettype wire

// ==== dv/kbd_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kbd_config.svh"

module kbd_tb;

    localparam int HALF_BIT = 40;
    localparam int N_FRAMES = 75;

    typedef struct packed {
        logic [7:0] seg_lo;
        logic [7:0] seg_hi;
        logic [7:0] count;
        logic       ovf;
    } expect_t;

    // Active-low gfedcba patterns for hex digits 0 to F
    localparam logic [6:0] SEG_TABLE [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    logic       clk;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_dat;
    logic       freeze;
    logic [7:0] seg_lo;
    logic [7:0] seg_hi;
    logic [7:0] press_count;
    logic       overflow;

    logic       m_shown;
    logic       m_break;
    logic [7:0] m_code;
    logic [7:0] m_count;
    logic       m_ovf;

    expect_t    exp_q [$];
    int         checks;
    int         errors;
    int         test_checks;
    int         test_errors;

    kbd_display_top dut (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_dat     (ps2_dat),
        .freeze      (freeze),
        .seg_lo      (seg_lo),
        .seg_hi      (seg_hi),
        .press_count (press_count),
        .overflow    (overflow)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial
    begin
        #(N_FRAMES * 11 * 2 * HALF_BIT * 8 * 2);
        $display("Watchdog expired before the tests finished");
        $display(">>> FAIL");
        $finish;
    end

    function automatic expect_t expected_outputs();
        expect_t e;
        e.seg_lo = m_shown ? {1'b1, SEG_TABLE[m_code[3:0]]} : 8'hff;
        e.seg_hi = m_shown ? {1'b1, SEG_TABLE[m_code[7:4]]} : 8'hff;
        e.count  = m_count;
        e.ovf    = m_ovf;
        return e;
    endfunction

    // Tracker rules applied to one byte taken from the FIFO
    function automatic expect_t apply_byte(input logic [7:0] code, input logic err);
        if (err)
            m_break = 1'b0;
        else if (m_break)
        begin
            // Only the release of the held key blanks the display
            if (code == m_code)
                m_shown = 1'b0;
            m_break = 1'b0;
        end
        else if (code == `KBD_BREAK_CODE)
            m_break = 1'b1;
        else
        begin
            m_code  = code;
            m_shown = 1'b1;
            m_count = m_count + 8'd1;
        end
        return expected_outputs();
    endfunction

    task automatic clear_model();
        m_shown = 1'b0;
        m_break = 1'b0;
        m_code  = 8'd0;
        m_count = 8'd0;
        m_ovf   = 1'b0;
    endtask

    function automatic logic [7:0] rand_make();
        logic [7:0] c;
        c = 8'($urandom);
        while (c == `KBD_BREAK_CODE)
            c = 8'($urandom);
        return c;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic check(input string name, input logic [7:0] got, input logic [7:0] want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("ERROR %0t ns: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    // Start bit, eight data bits LSB first, odd parity, stop bit
    task automatic drive_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++)
        begin
            @(posedge clk);
            ps2_dat <= bits[i];
            wait_cycles(HALF_BIT / 2);
            ps2_clk <= 1'b0;
            wait_cycles(HALF_BIT);
            ps2_clk <= 1'b1;
            wait_cycles(HALF_BIT / 2);
        end
        ps2_dat <= 1'b1;
    endtask

    task automatic post_expect(input expect_t e);
        exp_q.push_back(e);
        wait (exp_q.size() == 0);
        @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] code, input logic bad_parity);
        drive_frame(code, bad_parity);
        post_expect(apply_byte(code, bad_parity));
    endtask

    task automatic finish_test(input string name);
        $display("Test %s done: %0d checks, %0d errors", name,
                 checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    // Compares the outputs once the path from the last PS/2 edge has settled
    initial
    begin
        expect_t e;
        forever
        begin
            wait (exp_q.size() != 0);
            repeat (12) @(posedge clk);
            @(negedge clk);
            e = exp_q[0];
            check("seg_lo", seg_lo, e.seg_lo);
            check("seg_hi", seg_hi, e.seg_hi);
            check("press_count", press_count, e.count);
            check("overflow", {7'd0, overflow}, {7'd0, e.ovf});
            exp_q.delete(0);
        end
    end

    initial
    begin
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] held [`KBD_FIFO_DEPTH];
        expect_t    e;
        void'($urandom(32'he536_ac23));
        rst         = 1'b0;
        ps2_clk     = 1'b1;
        ps2_dat     = 1'b1;
        freeze      = 1'b0;
        checks      = 0;
        errors      = 0;
        test_checks = 0;
        test_errors = 0;
        clear_model();
        wait_cycles(2);
        rst <= 1'b1;
        wait_cycles(4);

        for (int i = 0; i < 20; i++)
        begin
            a = rand_make();
            send_byte(a, 1'b0);
            send_byte(`KBD_BREAK_CODE, 1'b0);
            send_byte(a, 1'b0);
        end
        finish_test("make_release");

        a = rand_make();
        b = rand_make();
        while (b == a)
            b = rand_make();
        send_byte(a, 1'b0);
        send_byte(b, 1'b0);
        send_byte(`KBD_BREAK_CODE, 1'b0);
        send_byte(a, 1'b0);
        finish_test("other_release");

        // The corrupt byte carries the held code, so a wrong release would blank it
        send_byte(`KBD_BREAK_CODE, 1'b0);
        send_byte(b, 1'b1);
        send_byte(rand_make(), 1'b0);
        finish_test("parity_error");

        freeze <= 1'b1;
        for (int i = 0; i < 6; i++)
        begin
            a = rand_make();
            if (i < `KBD_FIFO_DEPTH)
                held[i] = a;
            drive_frame(a, 1'b0);
            if (i >= `KBD_FIFO_DEPTH)
                m_ovf = 1'b1;
            post_expect(expected_outputs());
        end
        freeze <= 1'b0;
        e = expected_outputs();
        for (int i = 0; i < `KBD_FIFO_DEPTH; i++)
            e = apply_byte(held[i], 1'b0);
        post_expect(e);
        finish_test("freeze");

        send_byte(rand_make(), 1'b0);
        rst <= 1'b0;
        wait_cycles(2);
        rst <= 1'b1;
        clear_model();
        post_expect(expected_outputs());
        send_byte(rand_make(), 1'b0);
        finish_test("reset");

        $display("All tests done: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+design
design/kbd_pkg.sv
design/byte_link_if.sv
design/ps2_rx.sv
design/scan_fifo.sv
design/key_tracker.sv
design/seg_display.sv
design/kbd_display_top.sv
dv/kbd_props.sv
dv/kbd_tb.sv
